// ==== common/cnn_config.svh ====
`ifndef CNN_CONFIG_SVH
`define CNN_CONFIG_SVH

// input image is square
`define IMG_W 12

// filter geometry
`define KSIZE 5
`define KTAPS 25

// one PE per output channel
`define NUM_PE 8

// side of the pooled map (8x8 conv out, 2x2 pool)
`define POOL_W 4

// bram geometry, word addressed
`define WORD_BITS 32
`define ADDR_BITS 8

`endif

// ==== common/cnn_pkg.sv ====
`include "cnn_config.svh"

package cnn_pkg;

  // unsigned image pixel or pooled output byte
  typedef logic [7:0] pix_t;

  // filter tap
  typedef logic signed [7:0] wgt_t;

  // mac result before relu
  typedef logic signed [31:0] acc_t;

  // one bram word, seen whole or as four bytes
  // bytes[0] is the lowest byte address and sits in bits 31:24
  typedef union packed {
    logic [`WORD_BITS-1:0] word;
    pix_t [0:3]            bytes;
  } bram_word_u;

  // request toward any of the three brams
  typedef struct packed {
    logic [`ADDR_BITS-1:0] addr;
    logic                  en;
    logic                  we;   // write at this edge
    bram_word_u            din;
  } bram_req_t;

  // one 5x5 patch plus the pooled position it belongs to
  typedef struct packed {
    pix_t [0:`KTAPS-1] taps;   // row-major
    logic [3:0]        pos;    // 4*pr + pc
  } window_t;

endpackage

// ==== window_loader/window_loader.sv ====
`timescale 1ns/1ps
`include "cnn_config.svh"

module window_loader (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               i_start,
  output cnn_pkg::bram_req_t                 o_img_req,
  input  cnn_pkg::bram_word_u                i_img_rdata,
  output cnn_pkg::bram_req_t                 o_wgt_req,
  input  cnn_pkg::bram_word_u                i_wgt_rdata,
  output cnn_pkg::wgt_t [0:`NUM_PE*`KTAPS-1] o_weights,
  output cnn_pkg::window_t                   o_win,
  output logic                               o_win_valid
);

  localparam int BYTES_PER_WORD = `WORD_BITS / 8;
  localparam int WORDS_PER_ROW  = `IMG_W / BYTES_PER_WORD;
  localparam int LINE_ROWS      = `KSIZE + 1;                     // two windows high
  localparam int WGT_WORDS      = `NUM_PE * `KTAPS / BYTES_PER_WORD;
  localparam int ROW_WORDS      = LINE_ROWS * WORDS_PER_ROW;
  localparam int LAST_POS       = `POOL_W * `POOL_W - 1;

  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_WLOAD = 3'd1;
  localparam logic [2:0] S_RLOAD = 3'd2;
  localparam logic [2:0] S_WIN   = 3'd3;
  localparam logic [2:0] S_DONE  = 3'd4;

  logic [2:0] state;
  logic [5:0] cnt;        // word or window counter of the current phase
  logic [3:0] pos;        // pooled position, {pr, pc}
  logic       wgt_pend;
  logic       img_pend;
  logic [5:0] pend_idx;   // word index of the read in flight
  logic [1:0] off;        // {row, col} offset of the window
  logic [3:0] col0;

  cnn_pkg::pix_t [0:LINE_ROWS*`IMG_W-1] line_c;   // rows 2pr..2pr+5
  cnn_pkg::pix_t [0:`KTAPS-1]           taps;

  // phase FSM
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= S_IDLE;
      cnt   <= '0;
      pos   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (i_start) begin
            state <= S_WLOAD;
            cnt   <= '0;
            pos   <= '0;
          end
        end
        S_WLOAD: begin
          if (cnt == 6'(WGT_WORDS - 1)) begin
            state <= S_RLOAD;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 6'd1;
          end
        end
        S_RLOAD: begin
          if (cnt == 6'(ROW_WORDS - 1)) begin
            state <= S_WIN;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 6'd1;
          end
        end
        S_WIN: begin
          // cnt 0 lets the last row word land, 1..4 issue windows
          if (cnt == 6'd4) begin
            cnt   <= '0;
            pos   <= pos + 4'd1;
            state <= (pos == 4'(LAST_POS)) ? S_DONE : S_RLOAD;
          end else begin
            cnt <= cnt + 6'd1;
          end
        end
        S_DONE:  state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // bram requests straight from the phase
  always_comb begin
    o_wgt_req      = '0;
    o_wgt_req.en   = (state == S_WLOAD);
    o_wgt_req.addr = `ADDR_BITS'(cnt);
    o_img_req      = '0;
    o_img_req.en   = (state == S_RLOAD);
    o_img_req.addr = `ADDR_BITS'(pos[3:2]) * `ADDR_BITS'(2 * WORDS_PER_ROW)
                     + `ADDR_BITS'(cnt);
  end

  // read data shows up one cycle after the request
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wgt_pend    <= 1'b0;
      img_pend    <= 1'b0;
      pend_idx    <= '0;
      o_weights   <= '0;
      line_c      <= '0;
      o_win_valid <= 1'b0;
    end else begin
      wgt_pend    <= o_wgt_req.en;
      img_pend    <= o_img_req.en;
      pend_idx    <= cnt;
      o_win_valid <= (state == S_WIN) && (cnt != '0);
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (wgt_pend) begin
          o_weights[pend_idx*BYTES_PER_WORD + b] <= i_wgt_rdata.bytes[b];
        end
        if (img_pend) begin
          line_c[pend_idx*BYTES_PER_WORD + b] <= i_img_rdata.bytes[b];
        end
      end
    end
  end

  // cnt 1..4 gives offsets (0,0) (0,1) (1,0) (1,1)
  always_comb begin
    off  = cnt[1:0] - 2'd1;
    col0 = {1'b0, pos[1:0], 1'b0} + {3'b000, off[0]};
    for (int j = 0; j < `KSIZE; j++) begin
      for (int i = 0; i < `KSIZE; i++) begin
        taps[j*`KSIZE + i] = line_c[(j + off[1]) * `IMG_W + col0 + i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_WIN && cnt != '0) begin
      o_win.taps <= taps;
      o_win.pos  <= pos;
    end
  end

  // windows are cut from a settled line cache only
  a_win_after_reads: assert property (@(posedge clk) disable iff (rst)
    o_win_valid |-> !$past(img_pend || wgt_pend));

endmodule

// ==== src/conv_pe.sv ====
`timescale 1ns/1ps
`include "cnn_config.svh"

module conv_pe (
  input  logic                       clk,
  input  logic                       rst,
  input  cnn_pkg::window_t           i_win,
  input  logic                       i_valid,
  input  cnn_pkg::wgt_t [0:`KTAPS-1] i_weights,
  output cnn_pkg::pix_t              o_pix,
  output logic [3:0]                 o_pos,
  output logic                       o_valid
);

  cnn_pkg::acc_t sum_c;
  cnn_pkg::acc_t sum_q;
  cnn_pkg::acc_t relu;
  cnn_pkg::pix_t quant;
  logic [3:0]    pos_q;
  logic          valid_q;

  // 25 taps, pixel zero-extended before the signed multiply
  always_comb begin
    sum_c = '0;
    for (int t = 0; t < `KTAPS; t++) begin
      sum_c = sum_c + cnn_pkg::acc_t'($signed({1'b0, i_win.taps[t]}))
                      * cnn_pkg::acc_t'(i_weights[t]);
    end
  end

  // relu then round to 8 bits with saturation
  always_comb begin
    relu = sum_q[31] ? '0 : sum_q;
    if (|relu[31:15]) begin
      quant = 8'hff;
    end else if (&relu[14:7]) begin
      quant = relu[14:7];   // rounding would wrap
    end else begin
      quant = relu[14:7] + {7'd0, relu[6]};
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
      o_valid <= 1'b0;
    end else begin
      valid_q <= i_valid;
      o_valid <= valid_q;
    end
  end

  always_ff @(posedge clk) begin
    sum_q <= sum_c;        // stage 1
    pos_q <= i_win.pos;
    o_pix <= quant;        // stage 2
    o_pos <= pos_q;
  end

endmodule

// ==== src/pool_writer.sv ====
`timescale 1ns/1ps
`include "cnn_config.svh"

module pool_writer (
  input  logic               clk,
  input  logic               rst,
  input  cnn_pkg::pix_t      i_pix [`NUM_PE],
  input  logic [3:0]         i_pos,
  input  logic               i_valid,
  output cnn_pkg::bram_req_t o_out_req,
  output logic               o_all_written
);

  localparam int LAST_POS    = `POOL_W * `POOL_W - 1;
  localparam int CH_PER_WORD = `WORD_BITS / 8;

  cnn_pkg::pix_t       mx [`NUM_PE];    // running max of the group
  cnn_pkg::pix_t       fin [`NUM_PE];
  cnn_pkg::bram_word_u lo_word;
  cnn_pkg::bram_word_u hi_word;
  cnn_pkg::bram_word_u hi_q;
  logic [2:0]          grp_cnt;         // results seen in this group
  logic [3:0]          grp_pos;
  logic                hi_pend;         // second word goes out next

  // max including the incoming result, first result starts fresh
  always_comb begin
    for (int c = 0; c < `NUM_PE; c++) begin
      fin[c] = (grp_cnt == '0 || i_pix[c] > mx[c]) ? i_pix[c] : mx[c];
    end
    for (int b = 0; b < CH_PER_WORD; b++) begin
      lo_word.bytes[b] = fin[b];
      hi_word.bytes[b] = fin[b + CH_PER_WORD];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      grp_cnt       <= '0;
      hi_pend       <= 1'b0;
      o_out_req     <= '0;
      o_all_written <= 1'b0;
    end else begin
      hi_pend       <= 1'b0;
      o_all_written <= 1'b0;
      o_out_req.en  <= 1'b0;
      o_out_req.we  <= 1'b0;
      if (i_valid) begin
        grp_cnt <= (grp_cnt == 3'd3) ? 3'd0 : grp_cnt + 3'd1;
        if (grp_cnt == 3'd3) begin
          o_out_req.addr <= `ADDR_BITS'({i_pos, 1'b0});   // channels 0..3
          o_out_req.en   <= 1'b1;
          o_out_req.we   <= 1'b1;
          o_out_req.din  <= lo_word;
          hi_pend        <= 1'b1;
        end
      end
      if (hi_pend) begin
        o_out_req.addr <= `ADDR_BITS'({grp_pos, 1'b1});   // channels 4..7
        o_out_req.en   <= 1'b1;
        o_out_req.we   <= 1'b1;
        o_out_req.din  <= hi_q;
        o_all_written  <= (grp_pos == 4'(LAST_POS));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      for (int c = 0; c < `NUM_PE; c++) begin
        mx[c] <= fin[c];
      end
      if (grp_cnt == '0) begin
        grp_pos <= i_pos;
      end
      hi_q <= hi_word;
    end
  end

  // a group is four back to back results of one position
  a_group: assert property (@(posedge clk) disable iff (rst)
    grp_cnt != '0 |-> i_valid && i_pos == grp_pos);

  // loader spacing leaves room for the second write
  a_spacing: assert property (@(posedge clk) disable iff (rst)
    hi_pend |-> !i_valid);

endmodule

// ==== src/cnn_top.sv ====
`timescale 1ns/1ps
`include "cnn_config.svh"

module cnn_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_start,
  output logic                o_done,
  output cnn_pkg::bram_req_t  o_img_req,
  input  cnn_pkg::bram_word_u i_img_rdata,
  output cnn_pkg::bram_req_t  o_wgt_req,
  input  cnn_pkg::bram_word_u i_wgt_rdata,
  output cnn_pkg::bram_req_t  o_out_req
);

  cnn_pkg::wgt_t [0:`NUM_PE*`KTAPS-1] weights;   // all filters, filter k at 25k
  cnn_pkg::window_t                   win;
  logic                               win_valid;
  cnn_pkg::pix_t                      pe_pix [`NUM_PE];
  logic [3:0]                         pe_pos [`NUM_PE];
  logic                               pe_valid [`NUM_PE];
  logic                               all_written;

  window_loader u_loader (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .o_img_req   (o_img_req),
    .i_img_rdata (i_img_rdata),
    .o_wgt_req   (o_wgt_req),
    .i_wgt_rdata (i_wgt_rdata),
    .o_weights   (weights),
    .o_win       (win),
    .o_win_valid (win_valid)
  );

  // same window into every PE, each with its own filter
  for (genvar g = 0; g < `NUM_PE; g++) begin : g_pe
    conv_pe u_pe (
      .clk       (clk),
      .rst       (rst),
      .i_win     (win),
      .i_valid   (win_valid),
      .i_weights (weights[g*`KTAPS +: `KTAPS]),
      .o_pix     (pe_pix[g]),
      .o_pos     (pe_pos[g]),
      .o_valid   (pe_valid[g])
    );
  end

  // writer only looks at PE 0 for valid and pos
  pool_writer u_writer (
    .clk           (clk),
    .rst           (rst),
    .i_pix         (pe_pix),
    .i_pos         (pe_pos[0]),
    .i_valid       (pe_valid[0]),
    .o_out_req     (o_out_req),
    .o_all_written (all_written)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_done <= 1'b0;
    end else if (all_written) begin
      o_done <= 1'b1;
    end else if (i_start) begin
      o_done <= 1'b0;   // new run
    end
  end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #50 o_clk = ~o_clk;   // 100 ns period
  end

  initial begin
    o_rst = 1'b1;
    repeat (4) @(negedge o_clk);
    o_rst = 1'b0;   // released between rising edges
  end

endmodule

// ==== test/tb_cnn.sv ====
`timescale 1ns/1ps
`include "cnn_config.svh"

module tb_cnn;

  localparam int OUT_WORDS    = 2 * `POOL_W * `POOL_W;
  localparam int DONE_TIMEOUT = 3000;   // cycles, a run takes about 420

  logic                clk;
  logic                rst;
  logic                i_start;
  logic                o_done;
  cnn_pkg::bram_req_t  img_req;
  cnn_pkg::bram_req_t  wgt_req;
  cnn_pkg::bram_req_t  out_req;
  cnn_pkg::bram_word_u img_rdata = '0;
  cnn_pkg::bram_word_u wgt_rdata = '0;

  logic [31:0]       img_mem [256];
  logic [31:0]       wgt_mem [256];
  logic [31:0]       out_mem [256];
  logic [31:0]       exp_mem [OUT_WORDS];
  logic [7:0]        img_px [`IMG_W*`IMG_W];   // pixel (r,c) at 12r+c
  logic signed [7:0] wgt_b [`NUM_PE*`KTAPS];   // tap t of filter k at 25k+t
  logic [31:0]       rng_state;
  logic              fill_out;
  int                write_cnt = 0;

  tb_clock u_clock (.o_clk(clk), .o_rst(rst));

  cnn_top uut (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .o_done      (o_done),
    .o_img_req   (img_req),
    .i_img_rdata (img_rdata),
    .o_wgt_req   (wgt_req),
    .i_wgt_rdata (wgt_rdata),
    .o_out_req   (out_req)
  );

  // memory models, read data one edge after the request
  always @(posedge clk) begin
    if (img_req.en && !img_req.we) begin
      img_rdata.word <= img_mem[img_req.addr];
    end
    if (wgt_req.en && !wgt_req.we) begin
      wgt_rdata.word <= wgt_mem[wgt_req.addr];
    end
    if (fill_out) begin
      for (int a = 0; a < OUT_WORDS; a++) begin
        out_mem[a] <= 32'hc35a_0000 + 32'(a) * 32'h0000_0101;   // stale marker
      end
    end
    if (out_req.we) begin
      if (out_req.addr >= 8'(OUT_WORDS)) begin
        $display("output write at address %0d lies outside the output map", out_req.addr);
        $display("CHECKS FAILED");
        $fatal(1);
      end else begin
        out_mem[out_req.addr] <= out_req.din.word;
        write_cnt <= write_cnt + 1;
      end
    end
  end

  // image and weight memories are read-only
  always @(posedge clk) begin
    if (img_req.we || wgt_req.we) begin
      $display("write request seen on the image or weight memory");
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // relu, then keep bits 14:7 rounded by bit 6, saturating at 255
  function automatic logic [7:0] quantize(input int sum);
    logic [31:0] r;
    r = (sum < 0) ? 32'd0 : 32'(sum);
    if (r[31:15] != 17'd0 || r[14:7] == 8'hff) begin
      return 8'hff;
    end
    return r[14:7] + {7'd0, r[6]};
  endfunction

  function automatic logic [7:0] conv_out(input int k, input int y, input int x);
    int sum;
    sum = 0;
    for (int j = 0; j < `KSIZE; j++) begin
      for (int i = 0; i < `KSIZE; i++) begin
        sum += int'(img_px[(y + j) * `IMG_W + x + i]) * int'(wgt_b[k * `KTAPS + j * `KSIZE + i]);
      end
    end
    return quantize(sum);
  endfunction

  task automatic build_expected();
    logic [7:0] best;
    logic [7:0] v;
    int         p;
    for (int pr = 0; pr < `POOL_W; pr++) begin
      for (int pc = 0; pc < `POOL_W; pc++) begin
        p = pr * `POOL_W + pc;
        for (int k = 0; k < `NUM_PE; k++) begin
          best = 8'd0;
          for (int d = 0; d < 4; d++) begin
            v = conv_out(k, 2 * pr + d / 2, 2 * pc + d % 2);
            best = (v > best) ? v : best;
          end
          exp_mem[2 * p + k / 4][31 - 8 * (k % 4) -: 8] = best;   // channel 0 on top
        end
      end
    end
  endtask

  task automatic fill_expected(input logic [31:0] value);
    for (int a = 0; a < OUT_WORDS; a++) begin
      exp_mem[a] = value;
    end
  endtask

  // wgt_mode 0 zero, 1 small signed, 2 full signed range
  task automatic randomize_data(input int wgt_mode);
    for (int i = 0; i < `IMG_W * `IMG_W; i++) begin
      rng_state = xorshift32(rng_state);
      img_px[i] = rng_state[7:0];
    end
    for (int i = 0; i < `NUM_PE * `KTAPS; i++) begin
      rng_state = xorshift32(rng_state);
      case (wgt_mode)
        0:       wgt_b[i] = 8'sd0;
        1:       wgt_b[i] = {{2{rng_state[5]}}, rng_state[5:0]};
        default: wgt_b[i] = rng_state[15:8];
      endcase
    end
  endtask

  task automatic load_memories();
    for (int w = 0; w < 256; w++) begin
      img_mem[w] = '0;
      wgt_mem[w] = '0;
    end
    for (int w = 0; w < `IMG_W * `IMG_W / 4; w++) begin
      img_mem[w] = {img_px[4 * w], img_px[4 * w + 1], img_px[4 * w + 2], img_px[4 * w + 3]};
    end
    for (int w = 0; w < `NUM_PE * `KTAPS / 4; w++) begin
      wgt_mem[w] = {wgt_b[4 * w], wgt_b[4 * w + 1], wgt_b[4 * w + 2], wgt_b[4 * w + 3]};
    end
  endtask

  task automatic start_and_wait();
    int cycles;
    @(negedge clk);
    i_start = 1'b1;
    @(negedge clk);
    i_start = 1'b0;
    check_eq("o_done", 32'(o_done), 32'h0);   // start clears done
    cycles = 0;
    while (o_done !== 1'b1) begin
      if (cycles == DONE_TIMEOUT) begin
        $display("timeout: o_done never came within %0d cycles of start", DONE_TIMEOUT);
        $display("CHECKS FAILED");
        $fatal(1);
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  task automatic run_and_compare();
    int writes_before;
    load_memories();
    @(negedge clk);
    fill_out = 1'b1;
    @(negedge clk);
    fill_out = 1'b0;
    writes_before = write_cnt;
    start_and_wait();
    check_eq("write_cnt", 32'(write_cnt - writes_before), 32'(OUT_WORDS));
    for (int a = 0; a < OUT_WORDS; a++) begin
      check_eq($sformatf("out_mem[%0d]", a), out_mem[a], exp_mem[a]);
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst !== 1'b0) begin
      if (cycles == 20) begin
        $display("reset was never released");
        $display("CHECKS FAILED");
        $fatal(1);
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  task automatic test_reset_state();
    repeat (4) begin
      @(negedge clk);
      check_eq("o_done", 32'(o_done), 32'h0);
      check_eq("img_req.en", 32'(img_req.en), 32'h0);
      check_eq("wgt_req.en", 32'(wgt_req.en), 32'h0);
      check_eq("out_req.we", 32'(out_req.we), 32'h0);
      check_eq("write_cnt", 32'(write_cnt), 32'h0);
    end
  endtask

  task automatic test_zero_weights();
    randomize_data(0);
    fill_expected(32'h0);
    run_and_compare();
  endtask

  task automatic test_random();
    randomize_data(1);   // small weights keep many sums in the rounding range
    build_expected();
    run_and_compare();
  endtask

  task automatic test_saturation();
    for (int i = 0; i < `IMG_W * `IMG_W; i++) begin
      img_px[i] = 8'hff;
    end
    for (int i = 0; i < `NUM_PE * `KTAPS; i++) begin
      wgt_b[i] = 8'sd127;
    end
    fill_expected(32'hffff_ffff);
    run_and_compare();
  endtask

  task automatic test_restart();
    check_eq("o_done", 32'(o_done), 32'h1);   // still high from the last run
    randomize_data(2);
    build_expected();
    run_and_compare();
  endtask

  initial begin
    i_start   = 1'b0;
    fill_out  = 1'b0;
    rng_state = 32'h2cb2_4323;
    wait_reset_release();
    test_reset_state();
    test_zero_weights();
    test_random();
    test_saturation();
    test_restart();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+common
common/cnn_pkg.sv
window_loader/window_loader.sv
src/conv_pe.sv
src/pool_writer.sv
src/cnn_top.sv
test/tb_clock.sv
test/tb_cnn.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_cnn -f filelist.f
out=$(./obj_dir/Vtb_cnn 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
